//--- compile.f
+incdir+.
div_pkg.sv
div_operand_prep.sv
div_iter_core.sv
div_result_fmt.sv
div_unit.sv
tb_div_unit.sv

//--- div_iter_core.sv
`timescale 1ns/1ps

module div_iter_core import div_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  div_init_t       init_i,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output logic [XLEN-1:0] quot_o,
  output logic [XLEN-1:0] rem_o,
  output div_init_t       info_o
);

  div_state_e          state_q;
  logic [CNT_W-1:0]    cnt_q;
  logic [2*XLEN-1:0]   acc_q;    // {partial remainder, quotient}
  div_init_t           info_q;

  logic                req_fire;
  logic                rsp_fire;
  logic [XLEN:0]       part_rem; // partial remainder after the shift, 65 bits
  logic [XLEN+1:0]     trial;
  logic                borrow;

  assign req_ready_o = (state_q == IDLE);
  assign rsp_valid_o = (state_q == DONE);
  assign req_fire    = req_valid_i & req_ready_o;
  assign rsp_fire    = rsp_valid_o & rsp_ready_i;

  // ----------------------------------------
  // trial subtraction
  // ----------------------------------------
  assign part_rem = acc_q[2*XLEN-1:XLEN-1];
  assign trial    = {1'b0, part_rem} - {2'b00, info_q.divisor_abs};
  assign borrow   = trial[XLEN+1];

  // control
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_fire) begin
            state_q <= init_i.is_special ? DONE : BUSY; // short path
            cnt_q   <= init_i.iter_count;
          end
        end
        BUSY: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1)) begin
            state_q <= DONE;  // last quotient bit
          end
        end
        DONE: begin
          if (rsp_fire) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // shift-subtract datapath
  always_ff @(posedge clk) begin
    if (req_fire) begin
      info_q <= init_i;
      acc_q  <= {{XLEN{1'b0}}, init_i.dividend_abs};
    end else if (state_q == BUSY) begin
      if (borrow) begin
        acc_q <= {part_rem[XLEN-1:0], acc_q[XLEN-2:0], 1'b0};
      end else begin
        acc_q <= {trial[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
      end
    end
  end

  assign quot_o = acc_q[XLEN-1:0];
  assign rem_o  = acc_q[2*XLEN-1:XLEN];
  assign info_o = info_q;

  // ----------------------------------------
  // assertions
  // ----------------------------------------
  a_rsp_hold: assert property (@(posedge clk) disable iff (rst_n)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(quot_o) && $stable(rem_o))
    else $error("response dropped or changed under back-pressure");

  a_cnt_no_wrap: assert property (@(posedge clk) disable iff (rst_n)
    state_q == BUSY |-> cnt_q != '0)
    else $error("iteration counter wrapped in BUSY");

  a_one_side: assert property (@(posedge clk) disable iff (rst_n)
    !(req_ready_o && rsp_valid_o))
    else $error("req_ready_o and rsp_valid_o high together");

endmodule

//--- div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep import div_pkg::*; (
  input  div_req_t  req_i,
  output div_init_t init_o
);

  logic            is_word;
  logic            is_rem;
  logic            is_signed;

  logic [XLEN-1:0] a_ext;      // dividend after word extension
  logic [XLEN-1:0] b_ext;      // divisor after word extension
  logic [XLEN-1:0] a_sext32;   // sign-extended low word of dividend
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_abs;
  logic [XLEN-1:0] b_abs;

  logic            b_zero;
  logic            ovf;
  logic [XLEN-1:0] min_neg;
  logic [XLEN-1:0] spec_val;

  assign is_word   = op_is_word(req_i.op);
  assign is_rem    = op_is_rem(req_i.op);
  assign is_signed = op_is_signed(req_i.op);

  assign a_sext32 = {{(XLEN-WORD_W){req_i.dividend[WORD_W-1]}}, req_i.dividend[WORD_W-1:0]};

  // ----------------------------------------
  // operand extension and magnitudes
  // ----------------------------------------
  always_comb begin
    if (is_word) begin
      if (is_signed) begin
        a_ext = a_sext32;
        b_ext = {{(XLEN-WORD_W){req_i.divisor[WORD_W-1]}}, req_i.divisor[WORD_W-1:0]};
      end else begin
        a_ext = {{(XLEN-WORD_W){1'b0}}, req_i.dividend[WORD_W-1:0]};
        b_ext = {{(XLEN-WORD_W){1'b0}}, req_i.divisor[WORD_W-1:0]};
      end
    end else begin
      a_ext = req_i.dividend;
      b_ext = req_i.divisor;
    end
  end

  assign a_neg = is_signed & a_ext[XLEN-1];
  assign b_neg = is_signed & b_ext[XLEN-1];

  assign a_abs = a_neg ? (~a_ext + 1'b1) : a_ext;
  assign b_abs = b_neg ? (~b_ext + 1'b1) : b_ext;  // fits in low word for word ops

  // ----------------------------------------
  // special cases
  // ----------------------------------------
  assign b_zero  = (b_ext == '0);
  assign min_neg = is_word ? WORD_MIN_NEG : FULL_MIN_NEG;
  assign ovf     = is_signed & ~b_zero & (b_ext == '1) & (a_ext == min_neg);

  always_comb begin
    if (is_rem) begin
      // remainder gets the dividend on zero, 0 on overflow
      if (b_zero) begin
        spec_val = is_word ? a_sext32 : req_i.dividend;
      end else begin
        spec_val = '0;
      end
    end else begin
      spec_val = b_zero ? '1 : a_ext;  // overflow quotient is the dividend
    end
  end

  always_comb begin
    init_o.iter_count     = is_word ? CNT_W'(ITER_WORD) : CNT_W'(ITER_FULL);
    init_o.neg_quot       = a_neg ^ b_neg;
    init_o.neg_rem        = a_neg;
    init_o.dividend_abs   = is_word ? {a_abs[WORD_W-1:0], {WORD_W{1'b0}}} : a_abs;
    init_o.divisor_abs    = b_abs;
    init_o.is_special     = b_zero | ovf;
    init_o.special_result = spec_val;
    init_o.div_by_zero    = b_zero;
    init_o.overflow       = ovf;
    init_o.op             = req_i.op;
  end

endmodule

//--- div_pkg.sv
package div_pkg;

  // ----------------------------------------
  // widths and constants
  // ----------------------------------------
  localparam int XLEN      = 64;
  localparam int WORD_W    = 32;
  localparam int CNT_W     = 7;   // holds 64
  localparam int ITER_FULL = 64;
  localparam int ITER_WORD = 32;

  localparam logic [XLEN-1:0] FULL_MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [XLEN-1:0] WORD_MIN_NEG = {{(XLEN-WORD_W+1){1'b1}}, {(WORD_W-1){1'b0}}};

  // bit0 unsigned, bit1 word, bit2 remainder
  typedef enum logic [2:0] {
    DIV, DIVU, DIVW, DIVUW, REM, REMU, REMW, REMUW
  } div_op_e;

  typedef enum logic [1:0] {
    IDLE, BUSY, DONE
  } div_state_e;

  typedef struct packed {
    div_op_e         op;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
  } div_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            div_by_zero;
    logic            overflow;
  } div_rsp_t;

  // request facts handed from the operand stage to the core
  typedef struct packed {
    logic [CNT_W-1:0] iter_count;
    logic             neg_quot;
    logic             neg_rem;
    logic [XLEN-1:0]  dividend_abs;  // left-aligned for word ops
    logic [XLEN-1:0]  divisor_abs;
    logic             is_special;
    logic [XLEN-1:0]  special_result;
    logic             div_by_zero;
    logic             overflow;
    div_op_e          op;
  } div_init_t;

  function automatic logic op_is_word(div_op_e op);
    return op inside {DIVW, DIVUW, REMW, REMUW};
  endfunction

  function automatic logic op_is_rem(div_op_e op);
    return op inside {REM, REMU, REMW, REMUW};
  endfunction

  function automatic logic op_is_signed(div_op_e op);
    return op inside {DIV, DIVW, REM, REMW};
  endfunction

endpackage

//--- div_result_fmt.sv
`timescale 1ns/1ps

module div_result_fmt import div_pkg::*; (
  input  div_init_t       info_i,
  input  logic [XLEN-1:0] quot_i,
  input  logic [XLEN-1:0] rem_i,
  output div_rsp_t        rsp_o
);

  logic            is_word;
  logic            is_rem;
  logic            neg;
  logic [XLEN-1:0] raw;
  logic [XLEN-1:0] signed_val;
  logic [XLEN-1:0] fmt_val;

  assign is_word = op_is_word(info_i.op);
  assign is_rem  = op_is_rem(info_i.op);
  assign neg     = is_rem ? info_i.neg_rem : info_i.neg_quot;

  // word remainder sits in the low word of the upper half
  assign raw = is_rem ? rem_i : quot_i;

  // ----------------------------------------
  // sign restore and word extension
  // ----------------------------------------
  always_comb begin
    signed_val = neg ? (~raw + 1'b1) : raw;
    if (is_word) begin
      fmt_val = {{(XLEN-WORD_W){signed_val[WORD_W-1]}}, signed_val[WORD_W-1:0]};
    end else begin
      fmt_val = signed_val;
    end
  end

  always_comb begin
    if (info_i.is_special) begin
      rsp_o.result = info_i.special_result;  // zero divisor or overflow
    end else begin
      rsp_o.result = fmt_val;
    end
    rsp_o.div_by_zero = info_i.div_by_zero;
    rsp_o.overflow    = info_i.overflow;
  end

endmodule

//--- div_unit.sv
`timescale 1ns/1ps

module div_unit import div_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,

  // request side
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  div_req_t req_i,

  // response side
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output div_rsp_t rsp_o
);

  div_init_t       init;     // prep to core, combinational
  div_init_t       info;     // latched facts of the request in flight
  logic [XLEN-1:0] quot_raw;
  logic [XLEN-1:0] rem_raw;

  // ----------------------------------------
  // operand stage
  // ----------------------------------------
  div_operand_prep u_prep (
    .req_i  (req_i),
    .init_o (init)
  );

  // iterative core
  div_iter_core u_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .init_i      (init),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .quot_o      (quot_raw),
    .rem_o       (rem_raw),
    .info_o      (info)
  );

  div_result_fmt u_fmt (
    .info_i (info),
    .quot_i (quot_raw),
    .rem_i  (rem_raw),
    .rsp_o  (rsp_o)
  );

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tb_div_unit -o tb_div_unit
./obj_dir/tb_div_unit

//--- tb_div_checks.svh
`ifndef TB_DIV_CHECKS_SVH
`define TB_DIV_CHECKS_SVH

// ----------------------------------------
// reference model
// ----------------------------------------
// RISC-V M rules: truncate toward zero, remainder keeps the dividend sign
function automatic div_rsp_t model_div(div_op_e op, logic [63:0] a, logic [63:0] b);
  div_rsp_t    r;
  logic        word;
  logic        sgn;
  logic        want_rem;
  logic [63:0] q;
  logic [63:0] m;
  logic [31:0] a32;
  logic [31:0] b32;
  logic [31:0] q32;
  logic [31:0] m32;
  r        = '0;
  word     = op inside {DIVW, DIVUW, REMW, REMUW};
  sgn      = op inside {DIV, DIVW, REM, REMW};
  want_rem = op inside {REM, REMU, REMW, REMUW};
  a32      = a[31:0];
  b32      = b[31:0];
  if (!word) begin
    if (b == '0) begin
      q = '1;
      m = a;
      r.div_by_zero = 1'b1;
    end else if (sgn && a == 64'h8000_0000_0000_0000 && b == '1) begin
      q = a;
      m = '0;
      r.overflow = 1'b1;
    end else if (sgn) begin
      q = $signed(a) / $signed(b);
      m = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      m = a % b;
    end
  end else begin
    if (b32 == '0) begin
      q32 = '1;
      m32 = a32;
      r.div_by_zero = 1'b1;
    end else if (sgn && a32 == 32'h8000_0000 && b32 == '1) begin
      q32 = a32;
      m32 = '0;
      r.overflow = 1'b1;
    end else if (sgn) begin
      q32 = $signed(a32) / $signed(b32);
      m32 = $signed(a32) % $signed(b32);
    end else begin
      q32 = a32 / b32;
      m32 = a32 % b32;
    end
    q = {{32{q32[31]}}, q32};  // word results sign-extended
    m = {{32{m32[31]}}, m32};
  end
  r.result = want_rem ? m : q;
  return r;
endfunction

// full-width ops take 64 cycles, word ops 32
function automatic int iter_bound(div_op_e op);
  return (op inside {DIVW, DIVUW, REMW, REMUW}) ? 32 : 64;
endfunction

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic check_rsp(string name, div_op_e op, div_rsp_t exp, div_rsp_t act);
  if (act.result !== exp.result) begin
    $display("Error at %0t: %s.result (%s) expected %h, actual %h",
             $time, name, op.name(), exp.result, act.result);
    abort_run();
  end
  if (act.div_by_zero !== exp.div_by_zero || act.overflow !== exp.overflow) begin
    $display("Error at %0t: %s flags (%s) expected dbz=%b ovf=%b, actual dbz=%b ovf=%b",
             $time, name, op.name(), exp.div_by_zero, exp.overflow,
             act.div_by_zero, act.overflow);
    abort_run();
  end
endtask

task automatic check_handshake(string name, logic exp, logic act);
  if (act !== exp) begin
    $display("Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_cycles(string name, int exp, int act);
  if (act != exp) begin
    $display("Error at %0t: %s expected %0d cycles, actual %0d", $time, name, exp, act);
    abort_run();
  end
endtask

`endif

//--- tb_div_unit.sv
`timescale 1ns/1ps

module tb_div_unit import div_pkg::*; ();

  localparam int SEED            = 20155;
  localparam int CLK_PERIOD      = 100;
  localparam int NUM_REQS        = 265;  // 1 + 48 + 12 + 4 + 200
  localparam int WATCHDOG_CYCLES = NUM_REQS * 70 + 2000;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  logic     req_ready;
  div_req_t req;
  logic     rsp_valid;
  logic     rsp_ready;
  div_rsp_t rsp;

  div_unit DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_i       (req),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_o       (rsp)
  );

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  `include "tb_div_checks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
    abort_run();
  end

  // ----------------------------------------
  // request and response driver
  // ----------------------------------------
  // starts and ends on a falling edge
  task automatic send_and_wait(input div_req_t r, input int hold,
                               output div_rsp_t got, output int lat);
    int waited;
    int limit;
    waited    = 0;
    limit     = iter_bound(r.op);
    req       = r;
    req_valid = 1'b1;
    while (!req_ready) begin
      @(negedge clk);
      waited++;
      if (waited > 200) begin
        $display("Request was never accepted, req_ready_o stayed low");
        abort_run();
      end
    end
    @(posedge clk);  // transfer edge
    @(negedge clk);
    req_valid = 1'b0;
    req       = div_req_t'(~r);  // junk while the core works on its latched copy
    lat       = 1;  // valid rising n edges after the transfer shows up at lat n+1
    while (!rsp_valid) begin
      check_handshake("req_ready_o", 1'b0, req_ready);
      if (lat > limit) begin
        $display("No response within %0d cycles for %s", limit, r.op.name());
        abort_run();
      end
      @(negedge clk);
      lat++;
    end
    got = rsp;
    check_handshake("req_ready_o", 1'b0, req_ready);
    repeat (hold) begin  // back-pressure
      @(negedge clk);
      check_handshake("rsp_valid_o", 1'b1, rsp_valid);
      check_handshake("req_ready_o", 1'b0, req_ready);
      check_rsp("rsp_o", r.op, got, rsp);
    end
    rsp_ready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    rsp_ready = 1'b0;
    check_handshake("rsp_valid_o", 1'b0, rsp_valid);
    check_handshake("req_ready_o", 1'b1, req_ready);
  endtask

  task automatic run_one(input div_op_e op, input logic [63:0] a, input logic [63:0] b,
                         input int hold, output int lat);
    div_req_t r;
    div_rsp_t got;
    r.op       = op;
    r.dividend = a;
    r.divisor  = b;
    send_and_wait(r, hold, got, lat);
    check_rsp("rsp_o", op, model_div(op, a, b), got);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_reset_state();
    int lat;
    check_handshake("req_ready_o", 1'b1, req_ready);
    check_handshake("rsp_valid_o", 1'b0, rsp_valid);
    run_one(DIVU, 64'd100, 64'd7, 0, lat);
  endtask

  task automatic test_fixed_ops();
    logic [63:0] a_set [6];
    logic [63:0] b_set [6];
    int          lat;
    a_set = '{64'd100, 64'hffff_ffff_ffff_ff9c, 64'd100, 64'hffff_ffff_ffff_ff9c,
              64'd5, 64'h1234_5678_ffff_ff38};
    b_set = '{64'd7, 64'd7, 64'hffff_ffff_ffff_fff9, 64'hffff_ffff_ffff_fff9,
              64'd1000, 64'h8765_4321_0000_000d};  // last pair has garbage upper words
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 6; j++) begin
        run_one(div_op_e'(i), a_set[j], b_set[j], 0, lat);
      end
    end
  endtask

  task automatic test_special_cases();
    div_op_e ovf_ops [4];
    div_op_e op;
    int      lat;
    ovf_ops = '{DIV, REM, DIVW, REMW};
    for (int i = 0; i < 8; i++) begin
      op = div_op_e'(i);
      // word ops see a zero low word under nonzero upper bits
      run_one(op, 64'h9abc_def0_1357_2468,
              (iter_bound(op) == 32) ? 64'hffff_ffff_0000_0000 : 64'd0, 0, lat);
      check_cycles("rsp_valid_o latency", 1, lat);
    end
    for (int i = 0; i < 4; i++) begin
      op = ovf_ops[i];
      if (iter_bound(op) == 32) begin
        run_one(op, 64'h1234_5678_8000_0000, 64'habcd_0000_ffff_ffff, 0, lat);
      end else begin
        run_one(op, 64'h8000_0000_0000_0000, '1, 0, lat);
      end
      check_cycles("rsp_valid_o latency", 1, lat);
    end
  endtask

  task automatic test_back_pressure();
    int lat;
    for (int i = 0; i < 4; i++) begin
      run_one(div_op_e'($urandom_range(7, 0)), {$urandom, $urandom},
              {$urandom, $urandom}, $urandom_range(20, 0), lat);
    end
  endtask

  task automatic test_random();
    div_op_e     op;
    logic [63:0] a;
    logic [63:0] b;
    int          kind;
    int          lat;
    for (int i = 0; i < 200; i++) begin
      op   = div_op_e'($urandom_range(7, 0));
      a    = {$urandom, $urandom};
      kind = $urandom_range(9, 0);
      case (kind)
        0: b = '0;
        1: b = 64'($urandom_range(15, 1));
        2: b = -64'($urandom_range(15, 1));
        3: b = {$urandom, 32'd0};
        4: begin
          a = {$urandom, 32'h8000_0000};  // word overflow candidate
          b = '1;
        end
        5: begin
          a = 64'h8000_0000_0000_0000;
          b = '1;
        end
        default: b = {$urandom, $urandom};
      endcase
      run_one(op, a, b, 0, lat);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n     = 1'b1;  // reset is active high
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    @(negedge clk);
    test_reset_state();
    test_fixed_ops();
    test_special_cases();
    test_back_pressure();
    test_random();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
